// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f sim.f --top-module cpu_tb -o cpu_sim \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1 || echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== sim.f ====
source/cpu_pkg.sv
source/cpu_alu.sv
source/cpu_regfile.sv
source/cpu_sequencer.sv
source/cpu_top.sv
test/cpu_checker.sv
test/cpu_tb.sv

// ==== source/cpu_alu.sv ====
`default_nettype none

module cpu_alu (
    input  wire cpu_pkg::byte_t   op_a_i,
    input  wire cpu_pkg::byte_t   op_b_i,
    input  wire cpu_pkg::alu_op_e alu_op_i,
    input  wire                   carry_i,
    output cpu_pkg::byte_t        res_o,
    output cpu_pkg::byte_t        flags_o
);

    logic [8:0] sum;        // Bit 8 is carry or borrow
    logic [4:0] half;       // Bit 4 is half carry or borrow
    logic       cin;
    logic       ovf;
    logic       logic_op;

    // ------------------------------------------------------------
    // Result
    // ------------------------------------------------------------
    always_comb begin
        cin      = 1'b0;
        sum      = '0;
        half     = '0;
        ovf      = 1'b0;
        logic_op = 1'b0;

        case (alu_op_i)
            cpu_pkg::ALU_ADD,
            cpu_pkg::ALU_ADC: begin
                cin  = (alu_op_i == cpu_pkg::ALU_ADC) & carry_i;
                sum  = {1'b0, op_a_i} + {1'b0, op_b_i} + {8'h00, cin};
                half = {1'b0, op_a_i[3:0]} + {1'b0, op_b_i[3:0]} + {4'h0, cin};
                ovf  = (op_a_i[7] == op_b_i[7]) && (op_a_i[7] != sum[7]);
            end
            cpu_pkg::ALU_SUB,
            cpu_pkg::ALU_SBC,
            cpu_pkg::ALU_CP: begin
                cin  = (alu_op_i == cpu_pkg::ALU_SBC) & carry_i;
                sum  = {1'b0, op_a_i} - {1'b0, op_b_i} - {8'h00, cin};
                half = {1'b0, op_a_i[3:0]} - {1'b0, op_b_i[3:0]} - {4'h0, cin};
                ovf  = (op_a_i[7] != op_b_i[7]) && (op_a_i[7] != sum[7]);
            end
            cpu_pkg::ALU_AND: begin
                sum      = {1'b0, op_a_i & op_b_i};
                logic_op = 1'b1;
            end
            cpu_pkg::ALU_XOR: begin
                sum      = {1'b0, op_a_i ^ op_b_i};
                logic_op = 1'b1;
            end
            default: begin  // OR
                sum      = {1'b0, op_a_i | op_b_i};
                logic_op = 1'b1;
            end
        endcase
    end

    assign res_o = sum[7:0];

    // ------------------------------------------------------------
    // Flags
    // ------------------------------------------------------------
    always_comb begin
        flags_o = '0;               // Bits 5 and 3 stay clear
        flags_o[cpu_pkg::FLAG_S] = sum[7];
        flags_o[cpu_pkg::FLAG_Z] = (sum[7:0] == 8'h00);

        if (logic_op) begin
            flags_o[cpu_pkg::FLAG_P] = ~^sum[7:0];
        end else begin
            flags_o[cpu_pkg::FLAG_C] = sum[8];
            flags_o[cpu_pkg::FLAG_H] = half[4];
            // CP reports parity of the difference instead of overflow
            flags_o[cpu_pkg::FLAG_P] = (alu_op_i == cpu_pkg::ALU_CP) ? ~^sum[7:0] : ovf;
            flags_o[cpu_pkg::FLAG_N] = (alu_op_i == cpu_pkg::ALU_SUB) ||
                                       (alu_op_i == cpu_pkg::ALU_SBC) ||
                                       (alu_op_i == cpu_pkg::ALU_CP);
        end
    end

endmodule

`default_nettype wire

// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;

    // ALU operations in the order of opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_XOR,
        ALU_OR,
        ALU_CP
    } alu_op_e;

    // Register codes as they appear in the opcode
    typedef enum logic [2:0] {
        REG_B,
        REG_C,
        REG_D,
        REG_E,
        REG_H,
        REG_L,
        REG_M,      // Stands for the (HL) operand and names no register
        REG_A
    } reg_sel_e;

    // Jump conditions in the order of opcode bits 5:3
    typedef enum logic [2:0] {
        COND_NZ,
        COND_Z,
        COND_NC,
        COND_C,
        COND_PO,
        COND_PE,
        COND_P,
        COND_M
    } cond_e;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_EXEC1,
        ST_EXEC2,
        ST_EXEC3,
        ST_HALT
    } state_e;

    // ------------------------------------------------------------
    // Flag bit positions in F
    // ------------------------------------------------------------
    localparam int FLAG_C = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_P = 2;
    localparam int FLAG_H = 4;
    localparam int FLAG_Z = 6;
    localparam int FLAG_S = 7;

    // ------------------------------------------------------------
    // Single opcodes and instruction groups
    // ------------------------------------------------------------
    localparam byte_t OPC_NOP  = 8'h00;
    localparam byte_t OPC_HALT = 8'h76;
    localparam byte_t OPC_JP   = 8'hC3;
    localparam byte_t OPC_OUT  = 8'hD3;
    localparam byte_t OPC_IN   = 8'hDB;

    localparam byte_t OPC_MASK_LD_RN = 8'hC7;    // 00 ddd 110
    localparam byte_t OPC_LD_RN      = 8'h06;
    localparam byte_t OPC_MASK_LD_RR = 8'hC0;    // 01 ddd sss
    localparam byte_t OPC_LD_RR      = 8'h40;
    localparam byte_t OPC_MASK_ALU_R = 8'hC0;    // 10 ooo sss
    localparam byte_t OPC_ALU_R      = 8'h80;
    localparam byte_t OPC_MASK_ALU_N = 8'hC7;    // 11 ooo 110
    localparam byte_t OPC_ALU_N      = 8'hC6;
    localparam byte_t OPC_MASK_JP_CC = 8'hC7;    // 11 ccc 010
    localparam byte_t OPC_JP_CC      = 8'hC2;

    // F after reset has only Z set
    localparam byte_t FLAGS_RESET = 8'h40;

endpackage

`default_nettype wire

// ==== source/cpu_regfile.sv ====
`default_nettype none

module cpu_regfile (
    input  wire                    pin_clk,
    input  wire                    rst_n_i,
    input  wire cpu_pkg::reg_sel_e rd_sel_i,
    input  wire cpu_pkg::reg_sel_e wr_sel_i,
    input  wire                    wr_en_i,
    input  wire cpu_pkg::byte_t    wr_data_i,
    input  wire                    flag_we_i,
    input  wire cpu_pkg::byte_t    flag_data_i,
    output cpu_pkg::byte_t         rd_data_o,
    output cpu_pkg::byte_t         acc_o,
    output cpu_pkg::byte_t         flags_o
);

    // B C D E H L F A; slot 6 has no operand code, so F lives there
    cpu_pkg::byte_t regs_q [0:7];

    // ------------------------------------------------------------
    // Write ports
    // ------------------------------------------------------------
    always_ff @(posedge pin_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 8; i++) begin
                regs_q[i] <= '0;
            end
            regs_q[cpu_pkg::REG_M] <= cpu_pkg::FLAGS_RESET;
        end else begin
            if (wr_en_i && (wr_sel_i != cpu_pkg::REG_M)) begin
                regs_q[wr_sel_i] <= wr_data_i;
            end
            if (flag_we_i) begin
                regs_q[cpu_pkg::REG_M] <= flag_data_i;     // F only from here
            end
        end
    end

    // (HL) operand reads as zero
    assign rd_data_o = (rd_sel_i == cpu_pkg::REG_M) ? '0 : regs_q[rd_sel_i];
    assign acc_o     = regs_q[cpu_pkg::REG_A];
    assign flags_o   = regs_q[cpu_pkg::REG_M];

endmodule

`default_nettype wire

// ==== source/cpu_sequencer.sv ====
`default_nettype none

module cpu_sequencer (
    input  wire                    pin_clk,
    input  wire                    rst_n_i,
    input  wire cpu_pkg::byte_t    mem_data_i,
    input  wire cpu_pkg::byte_t    port_data_i,
    input  wire cpu_pkg::byte_t    rd_data_i,
    input  wire cpu_pkg::byte_t    acc_i,
    input  wire cpu_pkg::byte_t    flags_i,
    input  wire cpu_pkg::byte_t    alu_res_i,
    input  wire cpu_pkg::byte_t    alu_flags_i,
    output cpu_pkg::word_t         mem_addr_o,
    output cpu_pkg::byte_t         port_addr_o,
    output cpu_pkg::byte_t         port_data_o,
    output logic                   port_we_o,
    output logic                   halt_o,
    output cpu_pkg::reg_sel_e      rd_sel_o,
    output cpu_pkg::reg_sel_e      wr_sel_o,
    output logic                   wr_en_o,
    output cpu_pkg::byte_t         wr_data_o,
    output logic                   flag_we_o,
    output cpu_pkg::byte_t         flag_data_o,
    output cpu_pkg::byte_t         op_a_o,
    output cpu_pkg::byte_t         op_b_o,
    output cpu_pkg::alu_op_e       alu_op_o
);

    cpu_pkg::state_e state_q;
    cpu_pkg::word_t  pc_q;
    cpu_pkg::byte_t  opc_q;
    cpu_pkg::byte_t  addr_lo_q;     // Low byte of jump target
    cpu_pkg::byte_t  opc;
    logic            dec_halt, dec_ld_rn, dec_ld_rr, dec_alu_r, dec_alu_n;
    logic            dec_jp, dec_out, dec_in;
    logic            cond_true, jp_take;

    // ------------------------------------------------------------
    // Decode straight from the bus during fetch
    // ------------------------------------------------------------
    assign opc = (state_q == cpu_pkg::ST_FETCH) ? mem_data_i : opc_q;

    assign dec_halt  = (opc == cpu_pkg::OPC_HALT);
    assign dec_ld_rn = ((opc & cpu_pkg::OPC_MASK_LD_RN) == cpu_pkg::OPC_LD_RN);
    assign dec_ld_rr = ((opc & cpu_pkg::OPC_MASK_LD_RR) == cpu_pkg::OPC_LD_RR) && !dec_halt;
    assign dec_alu_r = ((opc & cpu_pkg::OPC_MASK_ALU_R) == cpu_pkg::OPC_ALU_R);
    assign dec_alu_n = ((opc & cpu_pkg::OPC_MASK_ALU_N) == cpu_pkg::OPC_ALU_N);
    assign dec_jp    = (opc == cpu_pkg::OPC_JP) ||
                       ((opc & cpu_pkg::OPC_MASK_JP_CC) == cpu_pkg::OPC_JP_CC);
    assign dec_out   = (opc == cpu_pkg::OPC_OUT);
    assign dec_in    = (opc == cpu_pkg::OPC_IN);

    always_comb begin
        case (cpu_pkg::cond_e'(opc_q[5:3]))
            cpu_pkg::COND_NZ: cond_true = !flags_i[cpu_pkg::FLAG_Z];
            cpu_pkg::COND_Z:  cond_true =  flags_i[cpu_pkg::FLAG_Z];
            cpu_pkg::COND_NC: cond_true = !flags_i[cpu_pkg::FLAG_C];
            cpu_pkg::COND_C:  cond_true =  flags_i[cpu_pkg::FLAG_C];
            cpu_pkg::COND_PO: cond_true = !flags_i[cpu_pkg::FLAG_P];
            cpu_pkg::COND_PE: cond_true =  flags_i[cpu_pkg::FLAG_P];
            cpu_pkg::COND_P:  cond_true = !flags_i[cpu_pkg::FLAG_S];
            default:          cond_true =  flags_i[cpu_pkg::FLAG_S];   // M
        endcase
        jp_take = (opc_q == cpu_pkg::OPC_JP) || cond_true;
    end

    // ------------------------------------------------------------
    // Step counter, PC and port registers
    // ------------------------------------------------------------
    always_ff @(posedge pin_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= cpu_pkg::ST_FETCH;
            pc_q        <= '0;
            opc_q       <= cpu_pkg::OPC_NOP;
            port_addr_o <= '0;
            port_data_o <= '0;
            port_we_o   <= 1'b0;
        end else begin
            port_we_o <= 1'b0;      // Strobe lasts one cycle
            case (state_q)
                cpu_pkg::ST_FETCH: begin
                    opc_q <= mem_data_i;
                    pc_q  <= pc_q + 16'd1;
                    if (dec_halt) begin
                        state_q <= cpu_pkg::ST_HALT;
                    end else if (dec_ld_rn || dec_ld_rr || dec_alu_r || dec_alu_n ||
                                 dec_jp || dec_out || dec_in) begin
                        state_q <= cpu_pkg::ST_EXEC1;
                    end
                end
                cpu_pkg::ST_EXEC1: begin
                    state_q <= (dec_alu_r || dec_alu_n || dec_in || dec_jp) ?
                               cpu_pkg::ST_EXEC2 : cpu_pkg::ST_FETCH;
                    if (dec_ld_rn || dec_alu_n || dec_jp || dec_out || dec_in) begin
                        pc_q <= pc_q + 16'd1;   // Immediate byte consumed
                    end
                    if (dec_out) begin
                        port_addr_o <= mem_data_i;
                        port_data_o <= acc_i;
                        port_we_o   <= 1'b1;
                    end
                    if (dec_in) port_addr_o <= mem_data_i;
                end
                cpu_pkg::ST_EXEC2: begin
                    state_q <= dec_jp ? cpu_pkg::ST_EXEC3 : cpu_pkg::ST_FETCH;
                end
                cpu_pkg::ST_EXEC3: begin
                    // Bus still points at the high byte
                    pc_q    <= jp_take ? {mem_data_i, addr_lo_q} : pc_q + 16'd1;
                    state_q <= cpu_pkg::ST_FETCH;
                end
                default: state_q <= cpu_pkg::ST_HALT;     // Until reset
            endcase
        end
    end

    // ALU operands and jump latch
    always_ff @(posedge pin_clk) begin
        if ((state_q == cpu_pkg::ST_FETCH) && (dec_alu_r || dec_alu_n)) begin
            op_a_o   <= acc_i;
            alu_op_o <= cpu_pkg::alu_op_e'(mem_data_i[5:3]);
        end
        if (state_q == cpu_pkg::ST_EXEC1) begin
            if (dec_alu_r) op_b_o <= rd_data_i;
            else if (dec_alu_n) op_b_o <= mem_data_i;
            if (dec_jp) addr_lo_q <= mem_data_i;
        end
    end

    // ------------------------------------------------------------
    // Write-back takes effect on the edge ending the last step
    // ------------------------------------------------------------
    always_comb begin
        rd_sel_o    = cpu_pkg::reg_sel_e'(opc_q[2:0]);     // Source field
        wr_sel_o    = cpu_pkg::REG_A;
        wr_en_o     = 1'b0;
        wr_data_o   = alu_res_i;
        flag_we_o   = 1'b0;
        flag_data_o = alu_flags_i;
        case (state_q)
            cpu_pkg::ST_EXEC1: begin
                wr_sel_o = cpu_pkg::reg_sel_e'(opc_q[5:3]);
                if (dec_ld_rn) begin
                    wr_en_o   = 1'b1;
                    wr_data_o = mem_data_i;
                end else if (dec_ld_rr) begin
                    wr_en_o   = 1'b1;
                    wr_data_o = rd_data_i;
                end
            end
            cpu_pkg::ST_EXEC2: begin
                if (dec_alu_r || dec_alu_n) begin
                    wr_en_o   = (alu_op_o != cpu_pkg::ALU_CP);     // CP sets flags only
                    flag_we_o = 1'b1;
                end else if (dec_in) begin
                    wr_en_o   = 1'b1;
                    wr_data_o = port_data_i;
                end
            end
            default: ;
        endcase
    end

    assign mem_addr_o = pc_q;
    assign halt_o     = (state_q == cpu_pkg::ST_HALT);

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`default_nettype none

module cpu_top (
    input  wire                 pin_clk,
    input  wire                 rst_n_i,
    output cpu_pkg::word_t      mem_addr_o,
    input  wire cpu_pkg::byte_t mem_data_i,
    output cpu_pkg::byte_t      port_addr_o,
    output cpu_pkg::byte_t      port_data_o,
    input  wire cpu_pkg::byte_t port_data_i,
    output logic                port_we_o,
    output logic                halt_o
);

    cpu_pkg::reg_sel_e rd_sel, wr_sel;
    cpu_pkg::byte_t    rd_data, wr_data, acc, flags, flag_data;
    cpu_pkg::byte_t    op_a, op_b, alu_res, alu_flags;
    cpu_pkg::alu_op_e  alu_op;
    logic              wr_en, flag_we;

    cpu_sequencer seq0 (
        .pin_clk     (pin_clk),
        .rst_n_i     (rst_n_i),
        .mem_data_i  (mem_data_i),
        .port_data_i (port_data_i),
        .rd_data_i   (rd_data),
        .acc_i       (acc),
        .flags_i     (flags),
        .alu_res_i   (alu_res),
        .alu_flags_i (alu_flags),
        .mem_addr_o  (mem_addr_o),
        .port_addr_o (port_addr_o),
        .port_data_o (port_data_o),
        .port_we_o   (port_we_o),
        .halt_o      (halt_o),
        .rd_sel_o    (rd_sel),
        .wr_sel_o    (wr_sel),
        .wr_en_o     (wr_en),
        .wr_data_o   (wr_data),
        .flag_we_o   (flag_we),
        .flag_data_o (flag_data),
        .op_a_o      (op_a),
        .op_b_o      (op_b),
        .alu_op_o    (alu_op)
    );

    cpu_alu alu0 (
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .alu_op_i (alu_op),
        .carry_i  (flags[cpu_pkg::FLAG_C]),   // For ADC and SBC
        .res_o    (alu_res),
        .flags_o  (alu_flags)
    );

    cpu_regfile rf0 (
        .pin_clk     (pin_clk),
        .rst_n_i     (rst_n_i),
        .rd_sel_i    (rd_sel),
        .wr_sel_i    (wr_sel),
        .wr_en_i     (wr_en),
        .wr_data_i   (wr_data),
        .flag_we_i   (flag_we),
        .flag_data_i (flag_data),
        .rd_data_o   (rd_data),
        .acc_o       (acc),
        .flags_o     (flags)
    );

endmodule

`default_nettype wire

// ==== test/cpu_checker.sv ====
`default_nettype none

module cpu_checker (
    input wire pin_clk,
    input wire rst_n_i,
    input wire port_we_i,
    input wire halt_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // ----------------------------------------------------------
    // Port strobe and halt behavior
    // ----------------------------------------------------------
    we_single_cycle: assert property (@(posedge pin_clk) disable iff (!rst_n_i)
        port_we_i |=> !port_we_i)
        else $error("port_we_o high on two consecutive cycles");

    halt_sticky: assert property (@(posedge pin_clk) disable iff (!rst_n_i)
        halt_i |=> halt_i)        // Only reset leaves halt
        else $error("halt_o dropped without reset");

    no_we_in_halt: assert property (@(posedge pin_clk) disable iff (!rst_n_i)
        halt_i |-> !port_we_i)
        else $error("port_we_o high while halted");

endmodule

bind cpu_top cpu_checker chk0 (
    .pin_clk   (pin_clk),
    .rst_n_i   (rst_n_i),
    .port_we_i (port_we_o),
    .halt_i    (halt_o)
);

`default_nettype wire

// ==== test/cpu_tb.sv ====
`default_nettype none

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic           pin_clk;
    logic           rst_n;
    cpu_pkg::word_t mem_addr;
    cpu_pkg::byte_t mem_data;
    cpu_pkg::byte_t port_addr;
    cpu_pkg::byte_t port_data_out;
    cpu_pkg::byte_t port_data_in;
    logic           port_we;
    logic           halt;

    cpu_pkg::byte_t rom [0:255];
    cpu_pkg::byte_t gen_pc;             // Next free ROM byte
    cpu_pkg::byte_t m_regs [0:7];       // B C D E H L, unused slot, A
    cpu_pkg::byte_t m_f;
    cpu_pkg::word_t exp_halt_addr;
    cpu_pkg::byte_t exp_addr_q [$];
    cpu_pkg::byte_t exp_data_q [$];

    cpu_top dut0 (
        .pin_clk     (pin_clk),
        .rst_n_i     (rst_n),
        .mem_addr_o  (mem_addr),
        .mem_data_i  (mem_data),
        .port_addr_o (port_addr),
        .port_data_o (port_data_out),
        .port_data_i (port_data_in),
        .port_we_o   (port_we),
        .halt_o      (halt)
    );

    // ROM and input port answer combinationally
    assign mem_data     = rom[mem_addr[7:0]];
    assign port_data_in = port_addr ^ 8'hA5;

    initial begin
        pin_clk = 1'b0;
        forever #2 pin_clk = ~pin_clk;
    end

    // ----------------------------------------------------------
    // Failure reporting and compares
    // ----------------------------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_port(input string name, input cpu_pkg::byte_t exp_addr,
                              input cpu_pkg::byte_t exp_data, input cpu_pkg::byte_t act_addr,
                              input cpu_pkg::byte_t act_data);
        if (exp_addr !== act_addr || exp_data !== act_data) begin
            report_failure($sformatf("Error: %s expected %02h:%02h actual %02h:%02h",
                                     name, exp_addr, exp_data, act_addr, act_data));
        end
    endtask

    task automatic check_halt(input string name, input cpu_pkg::word_t exp_addr,
                              input cpu_pkg::word_t act_addr);
        if (exp_addr !== act_addr) begin
            report_failure($sformatf("Error: %s expected %04h actual %04h",
                                     name, exp_addr, act_addr));
        end
    endtask

    // ----------------------------------------------------------
    // Program generation
    // ----------------------------------------------------------
    function automatic cpu_pkg::byte_t rand_byte();
        return 8'($urandom());
    endfunction

    // Opcodes outside the subset that run as one-byte NOPs
    function automatic cpu_pkg::byte_t other_opcode(input logic [2:0] k);
        case (k)
            3'd0:    return 8'h07;
            3'd1:    return 8'h10;
            3'd2:    return 8'h18;
            3'd3:    return 8'h27;
            3'd4:    return 8'hC9;
            3'd5:    return 8'hCD;
            3'd6:    return 8'hED;
            default: return 8'hF3;
        endcase
    endfunction

    task automatic emit_byte(input cpu_pkg::byte_t v);
        rom[gen_pc] = v;
        gen_pc = gen_pc + 8'd1;
    endtask

    task automatic build_program();
        logic [2:0]     d;
        logic [2:0]     s;
        logic [2:0]     o;
        cpu_pkg::byte_t n;
        cpu_pkg::byte_t tgt;
        int             kind;
        for (int i = 0; i < 256; i++) begin
            rom[i[7:0]] = i[7:0] ^ 8'hA7;       // Filler past HALT
        end
        gen_pc = 8'h00;
        while (gen_pc < 8'd240) begin
            kind = int'($urandom_range(9, 0));
            d    = 3'($urandom());
            s    = 3'($urandom());
            o    = 3'($urandom());
            n    = rand_byte();
            case (kind)
                0: begin
                    emit_byte({2'b00, d, 3'b110});  // LD r,n
                    emit_byte(n);
                end
                1: begin
                    if (d == 3'd6 && s == 3'd6) s = 3'd7;   // Keep clear of HALT
                    emit_byte({2'b01, d, s});
                end
                2, 3: begin
                    if (kind == 2) begin
                        emit_byte({2'b10, o, s});
                    end else begin
                        emit_byte({2'b11, o, 3'b110});
                        emit_byte(n);
                    end
                    if ($urandom_range(1, 0) == 1) begin
                        emit_byte(8'hD3);           // Expose A
                        emit_byte(rand_byte());
                    end
                end
                4: begin
                    emit_byte(8'hDB);
                    emit_byte(n);
                    emit_byte(8'hD3);
                    emit_byte(n);
                end
                5: begin
                    emit_byte(8'hD3);
                    emit_byte(n);
                end
                6, 7, 8: begin
                    // Forward jump over a marker OUT
                    emit_byte((kind == 8) ? 8'hC3 : {2'b11, o, 3'b010});
                    tgt = gen_pc + 8'd4;
                    emit_byte(tgt);
                    emit_byte(8'h00);
                    emit_byte(8'hD3);
                    emit_byte(8'hE0 | {5'b00000, o});
                end
                default: emit_byte(other_opcode(s));
            endcase
        end
        rom[gen_pc] = 8'h76;
    endtask

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic int to_signed(input cpu_pkg::byte_t v);
        return v[7] ? int'(v) - 256 : int'(v);
    endfunction

    function automatic logic even_parity(input cpu_pkg::byte_t v);
        cpu_pkg::byte_t w;
        int             ones;
        w    = v;
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            ones += int'(w[0]);
            w = w >> 1;
        end
        return (ones % 2) == 0;
    endfunction

    function automatic logic cond_holds(input logic [2:0] cc);
        case (cpu_pkg::cond_e'(cc))
            cpu_pkg::COND_NZ: return !m_f[cpu_pkg::FLAG_Z];
            cpu_pkg::COND_Z:  return m_f[cpu_pkg::FLAG_Z];
            cpu_pkg::COND_NC: return !m_f[cpu_pkg::FLAG_C];
            cpu_pkg::COND_C:  return m_f[cpu_pkg::FLAG_C];
            cpu_pkg::COND_PO: return !m_f[cpu_pkg::FLAG_P];
            cpu_pkg::COND_PE: return m_f[cpu_pkg::FLAG_P];
            cpu_pkg::COND_P:  return !m_f[cpu_pkg::FLAG_S];
            default:          return m_f[cpu_pkg::FLAG_S];
        endcase
    endfunction

    task automatic model_alu(input cpu_pkg::alu_op_e op, input cpu_pkg::byte_t b);
        int             a_u;
        int             b_u;
        int             cin;
        int             full;
        int             nib;
        int             sres;
        logic           c;
        logic           h;
        logic           p;
        logic           n;
        cpu_pkg::byte_t res;
        a_u  = int'(m_regs[7]);
        b_u  = int'(b);
        cin  = 0;
        full = 0;
        c    = 1'b0;
        h    = 1'b0;
        p    = 1'b0;
        n    = 1'b0;
        case (op)
            cpu_pkg::ALU_ADD, cpu_pkg::ALU_ADC: begin
                if (op == cpu_pkg::ALU_ADC) cin = int'(m_f[cpu_pkg::FLAG_C]);
                full = a_u + b_u + cin;
                nib  = (a_u % 16) + (b_u % 16) + cin;
                sres = to_signed(m_regs[7]) + to_signed(b) + cin;
                c    = full > 255;
                h    = nib > 15;
                p    = (sres > 127) || (sres < -128);    // Signed overflow
            end
            cpu_pkg::ALU_SUB, cpu_pkg::ALU_SBC, cpu_pkg::ALU_CP: begin
                if (op == cpu_pkg::ALU_SBC) cin = int'(m_f[cpu_pkg::FLAG_C]);
                full = a_u - b_u - cin;
                nib  = (a_u % 16) - (b_u % 16) - cin;
                sres = to_signed(m_regs[7]) - to_signed(b) - cin;
                c    = full < 0;
                h    = nib < 0;
                p    = (sres > 127) || (sres < -128);
                n    = 1'b1;
            end
            cpu_pkg::ALU_AND: full = a_u & b_u;
            cpu_pkg::ALU_XOR: full = a_u ^ b_u;
            default:          full = a_u | b_u;
        endcase
        res = full[7:0];
        if (op == cpu_pkg::ALU_AND || op == cpu_pkg::ALU_XOR || op == cpu_pkg::ALU_OR ||
            op == cpu_pkg::ALU_CP) begin
            p = even_parity(res);
        end
        m_f = 8'h00;
        m_f[cpu_pkg::FLAG_S] = res[7];
        m_f[cpu_pkg::FLAG_Z] = (res == 8'h00);
        m_f[cpu_pkg::FLAG_H] = h;
        m_f[cpu_pkg::FLAG_P] = p;
        m_f[cpu_pkg::FLAG_N] = n;
        m_f[cpu_pkg::FLAG_C] = c;
        if (op != cpu_pkg::ALU_CP) m_regs[7] = res;
    endtask

    task automatic run_model();
        cpu_pkg::word_t pc;
        cpu_pkg::byte_t op;
        cpu_pkg::byte_t lo;
        cpu_pkg::byte_t hi;
        cpu_pkg::byte_t src;
        logic           halted;
        int             steps;
        m_regs = '{default: 8'h00};
        m_f    = 8'h40;                     // Z set out of reset
        pc     = 16'h0000;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < 1000) begin
            op    = rom[pc[7:0]];
            pc    = pc + 16'd1;
            steps = steps + 1;
            src   = (op[2:0] == 3'd6) ? 8'h00 : m_regs[op[2:0]];   // No (HL) operand
            if (op == 8'h76) begin
                halted        = 1'b1;
                exp_halt_addr = pc;
            end else if (op[7:6] == 2'b00 && op[2:0] == 3'b110) begin
                if (op[5:3] != 3'd6) m_regs[op[5:3]] = rom[pc[7:0]];
                pc = pc + 16'd1;
            end else if (op[7:6] == 2'b01) begin
                if (op[5:3] != 3'd6) m_regs[op[5:3]] = src;
            end else if (op[7:6] == 2'b10) begin
                model_alu(cpu_pkg::alu_op_e'(op[5:3]), src);
            end else if (op[7:6] == 2'b11 && op[2:0] == 3'b110) begin
                model_alu(cpu_pkg::alu_op_e'(op[5:3]), rom[pc[7:0]]);
                pc = pc + 16'd1;
            end else if (op == 8'hC3 || (op[7:6] == 2'b11 && op[2:0] == 3'b010)) begin
                lo = rom[pc[7:0]];
                pc = pc + 16'd1;
                hi = rom[pc[7:0]];
                pc = pc + 16'd1;
                if (op == 8'hC3 || cond_holds(op[5:3])) pc = {hi, lo};
            end else if (op == 8'hD3) begin
                exp_addr_q.push_back(rom[pc[7:0]]);
                exp_data_q.push_back(m_regs[7]);
                pc = pc + 16'd1;
            end else if (op == 8'hDB) begin
                m_regs[7] = rom[pc[7:0]] ^ 8'hA5;
                pc = pc + 16'd1;
            end
        end
        if (!halted) report_failure("Reference model never reached HALT");
    endtask

    // ----------------------------------------------------------
    // Run until HALT and check each port write on the way
    // ----------------------------------------------------------
    task automatic wait_for_halt();
        int cycles;
        int writes;
        cycles = 0;
        writes = 0;
        while (halt !== 1'b1) begin
            if (cycles >= 4000) begin
                report_failure("Timeout: DUT did not halt within 4000 cycles");
            end else begin
                @(negedge pin_clk);
                cycles = cycles + 1;
                if (port_we === 1'b1) begin
                    if (exp_addr_q.size() == 0) begin
                        report_failure("DUT wrote the port more often than the model");
                    end else begin
                        check_port($sformatf("port write %0d", writes), exp_addr_q.pop_front(),
                                   exp_data_q.pop_front(), port_addr, port_data_out);
                        writes = writes + 1;
                    end
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'h8336fd86));
        rst_n = 1'b0;
        build_program();
        run_model();
        repeat (10) @(posedge pin_clk);
        rst_n <= 1'b1;

        @(negedge pin_clk);
        if (halt !== 1'b0 || port_we !== 1'b0) begin
            report_failure("halt_o or port_we_o not low after reset");
        end
        check_halt("first fetch address", 16'h0000, mem_addr);

        wait_for_halt();
        check_halt("halt address", exp_halt_addr, mem_addr);
        if (exp_addr_q.size() != 0) begin
            report_failure("DUT halted before all expected port writes");
        end

        // Halted core must stay quiet
        for (int i = 0; i < 20; i++) begin
            @(negedge pin_clk);
            if (port_we !== 1'b0 || halt !== 1'b1) begin
                report_failure("Port write or halt drop after HALT");
            end
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
